// File: rtl/cnn_pkg.sv
package cnn_pkg;

  // tile and kernel geometry
  localparam int TILE_ROWS   = 6;
  localparam int TILE_COLS   = 8;
  localparam int KSIZE       = 5;
  localparam int KTAPS       = KSIZE * KSIZE;
  localparam int NUM_CH      = 8;  // one PE per output channel
  localparam int WIN_ROWS    = 2;
  localparam int WIN_COLS    = 4;
  localparam int NUM_WIN     = WIN_ROWS * WIN_COLS;
  localparam int POOL_SIZE   = 4;
  localparam int NUM_GROUPS  = NUM_WIN / POOL_SIZE;

  // BRAM word counts, four bytes per word
  localparam int IF_WORDS    = TILE_ROWS * TILE_COLS / 4;
  localparam int W_WORDS     = NUM_CH * KTAPS / 4;
  localparam int OUT_WORDS   = NUM_CH * NUM_GROUPS / 4;

  localparam int QUANT_SHIFT = 6;

  typedef logic        [7:0]  pixel_t;
  typedef logic signed [7:0]  weight_t;
  typedef logic signed [31:0] acc_t;
  typedef logic        [31:0] word_t;
  typedef logic        [15:0] addr_t;

  // tap t = row * KSIZE + col
  typedef pixel_t  [KTAPS-1:0]  window_t;
  typedef weight_t [KTAPS-1:0]  kernel_t;
  typedef pixel_t  [NUM_CH-1:0] chan_pix_t;

  typedef enum logic [1:0] {IDLE, LOAD, ISSUE, FINISH} load_state_t;

  typedef struct packed {
    logic  en;
    addr_t addr;
  } bram_rd_t;

  typedef struct packed {
    logic       en;
    logic [3:0] we;
    addr_t      addr;
    word_t      din;
  } bram_wr_t;

endpackage

// File: rtl/tile_loader.sv
`timescale 1ns/1ps

module tile_loader (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   i_start,
  input  logic                                   i_pool_done,
  input  cnn_pkg::word_t                         i_if_dout,
  input  cnn_pkg::word_t                         i_w_dout,
  output cnn_pkg::bram_rd_t                      o_if_rd,
  output cnn_pkg::bram_rd_t                      o_w_rd,
  output logic                                   o_win_vld,
  output cnn_pkg::window_t                       o_window,
  output cnn_pkg::kernel_t [cnn_pkg::NUM_CH-1:0] o_kernels
);
  import cnn_pkg::*;

  load_state_t state_q;
  logic [5:0]  cnt_q;     // read address in LOAD, window number in ISSUE
  logic        if_vld_q;  // input word returning this cycle
  logic        w_vld_q;   // weight word returning this cycle
  logic [5:0]  idx_q;     // word index of the returning data
  logic        row_off;
  logic [1:0]  col_off;

  pixel_t  i_cache [TILE_ROWS*TILE_COLS];
  weight_t w_cache [NUM_CH*KTAPS];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          cnt_q <= '0;
          if (i_start) state_q <= LOAD;
        end
        LOAD: begin
          if (cnt_q == 6'(W_WORDS - 1)) begin
            state_q <= ISSUE;
            cnt_q   <= '0;
          end else begin
            cnt_q <= cnt_q + 6'd1;
          end
        end
        ISSUE: begin
          if (cnt_q == 6'(NUM_WIN - 1)) begin
            state_q <= FINISH;
            cnt_q   <= '0;
          end else begin
            cnt_q <= cnt_q + 6'd1;
          end
        end
        FINISH: begin
          if (i_pool_done) state_q <= IDLE;  // writer has flushed the results
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // weights stream for the whole of LOAD, pixels only the first IF_WORDS cycles
  always_comb begin
    o_w_rd.en    = (state_q == LOAD);
    o_w_rd.addr  = addr_t'(cnt_q);
    o_if_rd.en   = (state_q == LOAD) && (cnt_q < 6'(IF_WORDS));
    o_if_rd.addr = addr_t'(cnt_q);
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      if_vld_q <= 1'b0;
      w_vld_q  <= 1'b0;
      idx_q    <= '0;
    end else begin
      if_vld_q <= o_if_rd.en;
      w_vld_q  <= o_w_rd.en;
      idx_q    <= cnt_q;
    end
  end

  // leftmost byte sits in the MSB
  always_ff @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (if_vld_q) i_cache[4*idx_q + b] <= i_if_dout[31-8*b -: 8];
      if (w_vld_q)  w_cache[4*idx_q + b] <= i_w_dout[31-8*b -: 8];
    end
  end

  // order (0,0) (0,1) (1,0) (1,1), then the same two columns further right
  assign row_off = cnt_q[1];
  assign col_off = {cnt_q[2], cnt_q[0]};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) o_win_vld <= 1'b0;
    else     o_win_vld <= (state_q == ISSUE);
  end

  always_ff @(posedge clk) begin
    if (state_q == ISSUE) begin
      for (int r = 0; r < KSIZE; r++) begin
        for (int c = 0; c < KSIZE; c++) begin
          o_window[r*KSIZE + c] <= i_cache[(r + row_off)*TILE_COLS + c + col_off];
        end
      end
    end
  end

  always_comb begin
    for (int ch = 0; ch < NUM_CH; ch++) begin
      for (int t = 0; t < KTAPS; t++) begin
        o_kernels[ch][t] = w_cache[ch*KTAPS + t];
      end
    end
  end

  // windows only leave after the caches are complete
  a_cache_steady: assert property (@(posedge clk) disable iff (rst)
    o_win_vld |-> !(if_vld_q || w_vld_q));

  a_done_in_finish: assert property (@(posedge clk) disable iff (rst)
    i_pool_done |-> (state_q == FINISH));  // writer ends after the last window

endmodule

// File: rtl/conv_pe.sv
`timescale 1ns/1ps

module conv_pe (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_vld,
  input  cnn_pkg::window_t i_window,
  input  cnn_pkg::kernel_t i_kernel,
  output logic             o_vld,
  output cnn_pkg::pixel_t  o_pix
);
  import cnn_pkg::*;

  acc_t   acc;
  acc_t   shifted;
  pixel_t q_pix;

  always_comb begin
    acc = '0;
    for (int t = 0; t < KTAPS; t++) begin
      acc = acc + acc_t'(i_window[t]) * acc_t'($signed(i_kernel[t]));  // unsigned pixel
    end
    shifted = acc >>> QUANT_SHIFT;
    if (acc < 0)             q_pix = '0;     // relu
    else if (shifted > 255)  q_pix = 8'hff;  // saturate
    else                     q_pix = shifted[7:0];
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) o_vld <= 1'b0;
    else     o_vld <= i_vld;
  end

  always_ff @(posedge clk) begin
    if (i_vld) o_pix <= q_pix;
  end

endmodule

// File: rtl/pool_buffer.sv
`timescale 1ns/1ps

module pool_buffer (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic                                         i_vld,
  input  cnn_pkg::chan_pix_t                           i_pix,
  output logic                                         o_grp_full,
  output cnn_pkg::chan_pix_t [cnn_pkg::POOL_SIZE-1:0]  o_entries
);
  import cnn_pkg::*;

  logic [1:0] fill_q;  // results stored in the current group

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fill_q     <= '0;
      o_grp_full <= 1'b0;
    end else begin
      o_grp_full <= i_vld && (fill_q == 2'(POOL_SIZE - 1));  // shows with the 4th entry
      if (i_vld) fill_q <= fill_q + 2'd1;
    end
  end

  // newest result at entry 0
  always_ff @(posedge clk) begin
    if (i_vld) begin
      o_entries[0] <= i_pix;
      for (int i = 1; i < POOL_SIZE; i++) begin
        o_entries[i] <= o_entries[i-1];
      end
    end
  end

  // a started group always completes in consecutive cycles
  a_grp_no_gap: assert property (@(posedge clk) disable iff (rst)
    (fill_q != 2'd0) |-> i_vld);

endmodule

// File: rtl/pool_writer.sv
`timescale 1ns/1ps

module pool_writer (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic                                         i_grp_full,
  input  cnn_pkg::chan_pix_t [cnn_pkg::POOL_SIZE-1:0]  i_entries,
  output cnn_pkg::bram_wr_t                            o_tmp_wr,
  output logic                                         o_done
);
  import cnn_pkg::*;

  chan_pix_t grp_max;
  chan_pix_t bank [NUM_GROUPS];  // pooled bytes per group
  logic      grp_q;              // group being captured next
  logic      wr_act_q;
  logic [1:0] wr_cnt_q;
  logic [2:0] ch0;
  logic [2:0] ch1;

  // 2x2 max per channel
  always_comb begin
    for (int c = 0; c < NUM_CH; c++) begin
      grp_max[c] = i_entries[0][c];
      for (int i = 1; i < POOL_SIZE; i++) begin
        if (i_entries[i][c] > grp_max[c]) grp_max[c] = i_entries[i][c];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_grp_full) bank[grp_q] <= grp_max;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      grp_q    <= 1'b0;
      wr_act_q <= 1'b0;
      wr_cnt_q <= '0;
      o_done   <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_grp_full) begin
        grp_q <= ~grp_q;
        if (grp_q) begin  // second group in, start flushing
          wr_act_q <= 1'b1;
          wr_cnt_q <= '0;
        end
      end
      if (wr_act_q) begin
        wr_cnt_q <= wr_cnt_q + 2'd1;
        if (wr_cnt_q == 2'(OUT_WORDS - 1)) begin
          wr_act_q <= 1'b0;
          o_done   <= 1'b1;
        end
      end
    end
  end

  // word n carries channels 2n and 2n+1, both groups each
  assign ch0 = {wr_cnt_q, 1'b0};
  assign ch1 = {wr_cnt_q, 1'b1};

  always_comb begin
    o_tmp_wr.en   = wr_act_q;
    o_tmp_wr.we   = {4{wr_act_q}};
    o_tmp_wr.addr = addr_t'(wr_cnt_q);
    o_tmp_wr.din  = {bank[0][ch0], bank[1][ch0], bank[0][ch1], bank[1][ch1]};
  end

  // banks hold still until the flush is over
  a_no_grp_in_flush: assert property (@(posedge clk) disable iff (rst)
    i_grp_full |-> !wr_act_q);

endmodule

// File: rtl/cnn_top.sv
`timescale 1ns/1ps

module cnn_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_start,
  input  cnn_pkg::word_t    i_if_dout,
  input  cnn_pkg::word_t    i_w_dout,
  output cnn_pkg::bram_rd_t o_if_rd,
  output cnn_pkg::bram_rd_t o_w_rd,
  output cnn_pkg::bram_wr_t o_tmp_wr,
  output logic              o_done
);
  import cnn_pkg::*;

  logic                       win_vld;
  window_t                    window;
  kernel_t   [NUM_CH-1:0]     kernels;
  logic      [NUM_CH-1:0]     pe_vld_all;
  logic                       pe_vld;
  chan_pix_t                  pe_pix;
  logic                       grp_full;
  chan_pix_t [POOL_SIZE-1:0]  entries;

  tile_loader u_loader (
    .clk         (clk),
    .rst         (rst),
    .i_start     (i_start),
    .i_pool_done (o_done),
    .i_if_dout   (i_if_dout),
    .i_w_dout    (i_w_dout),
    .o_if_rd     (o_if_rd),
    .o_w_rd      (o_w_rd),
    .o_win_vld   (win_vld),
    .o_window    (window),
    .o_kernels   (kernels)
  );

  // same window to every PE, one kernel per channel
  for (genvar c = 0; c < NUM_CH; c++) begin : g_pe
    conv_pe u_pe (
      .clk      (clk),
      .rst      (rst),
      .i_vld    (win_vld),
      .i_window (window),
      .i_kernel (kernels[c]),
      .o_vld    (pe_vld_all[c]),
      .o_pix    (pe_pix[c])
    );
  end

  assign pe_vld = pe_vld_all[0];  // all PEs run in lockstep

  pool_buffer u_buf (
    .clk        (clk),
    .rst        (rst),
    .i_vld      (pe_vld),
    .i_pix      (pe_pix),
    .o_grp_full (grp_full),
    .o_entries  (entries)
  );

  pool_writer u_writer (
    .clk        (clk),
    .rst        (rst),
    .i_grp_full (grp_full),
    .i_entries  (entries),
    .o_tmp_wr   (o_tmp_wr),
    .o_done     (o_done)
  );

endmodule

// File: sim/sim_brams.sv
`timescale 1ns/1ps

module sim_brams (
  input  logic              clk,
  input  logic              rst,
  // read ports seen by the DUT
  input  cnn_pkg::bram_rd_t i_if_rd,
  output cnn_pkg::word_t    o_if_dout,
  input  cnn_pkg::bram_rd_t i_w_rd,
  output cnn_pkg::word_t    o_w_dout,
  input  cnn_pkg::bram_wr_t i_tmp_wr,
  // preload port, sel 0 is the input memory and 1 the weight memory
  input  logic              i_ld_en,
  input  logic              i_ld_sel,
  input  cnn_pkg::addr_t    i_ld_addr,
  input  cnn_pkg::word_t    i_ld_data,
  // one entry per result write, read back a cycle later
  output logic              o_log_vld,
  output cnn_pkg::addr_t    o_log_addr,
  output cnn_pkg::word_t    o_log_data
);
  import cnn_pkg::*;

  word_t if_mem  [IF_WORDS];
  word_t w_mem   [W_WORDS];
  word_t tmp_mem [OUT_WORDS];

  always_ff @(posedge clk) begin
    if (i_ld_en && !i_ld_sel) if_mem[i_ld_addr] <= i_ld_data;
    if (i_ld_en && i_ld_sel)  w_mem[i_ld_addr]  <= i_ld_data;
    if (i_if_rd.en) o_if_dout <= if_mem[i_if_rd.addr];  // one cycle read latency
    if (i_w_rd.en)  o_w_dout  <= w_mem[i_w_rd.addr];
    for (int b = 0; b < 4; b++) begin
      if (i_tmp_wr.en && i_tmp_wr.we[b]) begin
        tmp_mem[i_tmp_wr.addr][8*b +: 8] <= i_tmp_wr.din[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_log_vld  <= 1'b0;
      o_log_addr <= '0;
    end else begin
      o_log_vld  <= i_tmp_wr.en;
      o_log_addr <= i_tmp_wr.addr;
    end
  end

  // stored word, byte enables included
  assign o_log_data = tmp_mem[o_log_addr];

endmodule

// File: sim/tb_cnn.sv
`timescale 1ns/1ps

module tb_cnn;
  import cnn_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int WATCH_RUNS = 5;
  localparam int RUN_CYCLES = 200;

  logic clk, rst, i_start, o_done;
  word_t if_dout, w_dout;
  bram_rd_t if_rd, w_rd;
  bram_wr_t tmp_wr;
  logic ld_en, ld_sel, log_vld;
  addr_t ld_addr, log_addr;
  word_t ld_data, log_data;

  word_t if_words [IF_WORDS];  // mirror of the preloaded memories
  word_t w_words  [W_WORDS];
  word_t got_words [OUT_WORDS];
  word_t first_words [OUT_WORDS];
  logic same_words;
  int unsigned rng_state;
  int wr_count, done_count;

  cnn_top DUT (
    .clk(clk), .rst(rst), .i_start(i_start), .i_if_dout(if_dout), .i_w_dout(w_dout),
    .o_if_rd(if_rd), .o_w_rd(w_rd), .o_tmp_wr(tmp_wr), .o_done(o_done)
  );

  sim_brams u_mem (
    .clk(clk), .rst(rst), .i_if_rd(if_rd), .o_if_dout(if_dout), .i_w_rd(w_rd),
    .o_w_dout(w_dout), .i_tmp_wr(tmp_wr), .i_ld_en(ld_en), .i_ld_sel(ld_sel),
    .i_ld_addr(ld_addr), .i_ld_data(ld_data), .o_log_vld(log_vld),
    .o_log_addr(log_addr), .o_log_data(log_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  function automatic pixel_t lcg_byte();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state[23:16];
  endfunction

  // word 2r+c/4, leftmost pixel in the top byte
  function automatic int pix_at(input int r, input int c);
    return int'(if_words[2*r + c/4][31 - 8*(c%4) -: 8]);
  endfunction

  function automatic int wt_at(input int ch, input int t);
    weight_t w;
    w = w_words[(25*ch + t) / 4][31 - 8*((25*ch + t) % 4) -: 8];
    return int'(w);
  endfunction

  function automatic int pe_out(input int ch, input int ro, input int co);
    int sum;
    sum = 0;
    for (int r = 0; r < KSIZE; r++)
      for (int c = 0; c < KSIZE; c++)
        sum += pix_at(ro + r, co + c) * wt_at(ch, r*KSIZE + c);
    if (sum < 0) return 0;  // relu
    sum = sum >> QUANT_SHIFT;
    return (sum > 255) ? 255 : sum;
  endfunction

  // group g covers column offsets 2g and 2g+1 on both rows
  function automatic int pool_max(input int ch, input int g);
    int m;
    m = 0;
    for (int dr = 0; dr < 2; dr++)
      for (int dc = 0; dc < 2; dc++)
        if (pe_out(ch, dr, 2*g + dc) > m) m = pe_out(ch, dr, 2*g + dc);
    return m;
  endfunction

  function automatic word_t ref_word(input int n);
    return {pixel_t'(pool_max(2*n, 0)), pixel_t'(pool_max(2*n, 1)),
            pixel_t'(pool_max(2*n+1, 0)), pixel_t'(pool_max(2*n+1, 1))};
  endfunction

  // mode 0 random, 1 negative weights, 2 all at maximum
  task automatic fill_mems(input int mode);
    for (int k = 0; k < IF_WORDS + W_WORDS; k++) begin
      ld_sel = (k >= IF_WORDS);
      ld_addr = addr_t'(ld_sel ? k - IF_WORDS : k);
      for (int b = 0; b < 4; b++) begin
        if (mode == 2) ld_data[31-8*b -: 8] = ld_sel ? 8'h7f : 8'hff;
        else if (mode == 1 && ld_sel) ld_data[31-8*b -: 8] = lcg_byte() | 8'h80;
        else ld_data[31-8*b -: 8] = lcg_byte();
      end
      if (ld_sel) w_words[ld_addr] = ld_data;
      else if_words[ld_addr] = ld_data;
      ld_en = 1'b1;
      @(posedge clk);
      #1;
    end
    ld_en = 1'b0;
  endtask

  task automatic run_once(input int run_no);
    wr_count = 0;
    i_start = 1'b1;
    @(posedge clk);
    #1 i_start = 1'b0;
    do @(negedge clk); while (!o_done);
    @(negedge clk);
    check_bit("o_done", o_done, 1'b0);  // single-cycle pulse
    if (wr_count != OUT_WORDS) fail_run($sformatf("run %0d made %0d result writes", run_no, wr_count));
    if (done_count != run_no) fail_run($sformatf("run %0d saw %0d done pulses", run_no, done_count));
    @(posedge clk);
    #1;
  endtask

  always @(negedge clk) begin
    if (log_vld) begin
      if (wr_count >= OUT_WORDS) fail_run("more than four result writes in one run");
      check_addr("o_tmp_wr.addr", log_addr, addr_t'(wr_count));
      check_word("o_tmp_wr.din", log_data, ref_word(wr_count));
      got_words[wr_count] = log_data;
      wr_count++;
    end
    if (o_done) done_count++;
  end

  initial begin
    #(WATCH_RUNS * RUN_CYCLES * CLK_PERIOD);
    fail_run("timeout, o_done never arrived");
  end

  initial begin
    rst = 1'b1;
    i_start = 1'b0;
    ld_en = 1'b0;
    ld_sel = 1'b0;
    ld_addr = '0;
    ld_data = '0;
    rng_state = 28;
    wr_count = 0;
    done_count = 0;
    repeat (16) @(posedge clk);
    #1 rst = 1'b0;
    repeat (4) begin  // idle, nothing may move
      @(negedge clk);
      check_bit("o_if_rd.en", if_rd.en, 1'b0);
      check_bit("o_w_rd.en", w_rd.en, 1'b0);
      check_bit("o_tmp_wr.en", tmp_wr.en, 1'b0);
      check_bit("o_done", o_done, 1'b0);
    end
    @(posedge clk);
    #1;
    fill_mems(0);
    run_once(1);
    first_words = got_words;
    fill_mems(1);
    run_once(2);
    for (int n = 0; n < OUT_WORDS; n++) check_word("relu word", got_words[n], 32'h0);
    fill_mems(2);
    run_once(3);
    for (int n = 0; n < OUT_WORDS; n++) check_word("saturated word", got_words[n], 32'hffffffff);
    fill_mems(0);
    run_once(4);
    same_words = 1'b1;
    for (int n = 0; n < OUT_WORDS; n++) begin
      if (got_words[n] !== first_words[n]) same_words = 1'b0;
    end
    if (same_words) fail_run("second random run repeated the first results");
    $display("Testbench passed");
    $finish;
  end

endmodule

// File: cnn.f
rtl/cnn_pkg.sv
rtl/tile_loader.sv
rtl/conv_pe.sv
rtl/pool_buffer.sv
rtl/pool_writer.sv
rtl/cnn_top.sv
sim/sim_brams.sv
sim/tb_cnn.sv
